// File: garegga_pkg.sv
// memory map, i/o and gp9001 offsets, bus widths, select and strobe types
package garegga_pkg;

    localparam int addr_w = 23;   // 68000 word address, A23..A1
    localparam int data_w = 16;
    localparam int rom_aw = 19;   // program rom word address

    typedef logic [data_w-1:0] word_t;
    typedef logic [7:0]        byte_t;
    typedef logic [addr_w:0]   baddr_t;   // byte address

    // byte address map
    localparam baddr_t rom_end      = 24'h0F_FFFF;
    localparam baddr_t wram_base    = 24'h10_0000;
    localparam baddr_t wram_size    = 24'h01_0000;
    localparam baddr_t sram_base    = 24'h21_8000;
    localparam baddr_t sram_size    = 24'h00_4000;
    localparam baddr_t io_page      = 24'h21_C000;
    localparam baddr_t io_size      = 24'h00_1000;
    localparam baddr_t gcu_region   = 24'h30_0000;
    localparam baddr_t palram_base  = 24'h40_0000;
    localparam baddr_t palram_size  = 24'h00_1000;
    localparam baddr_t txvram_base  = 24'h50_0000;
    localparam baddr_t txvram_size  = 24'h00_2000;
    localparam baddr_t latch_region = 24'h60_0000;
    localparam baddr_t page_1m      = 24'h10_0000;   // span of gcu and latch regions

    // ram depths, words except sram which is bytes
    localparam int wram_aw   = 15;
    localparam int sram_aw   = 14;
    localparam int palram_aw = 11;
    localparam int txvram_aw = 12;

    // offsets inside the i/o page
    localparam logic [11:0] io_in1    = 12'h020;
    localparam logic [11:0] io_in2    = 12'h024;
    localparam logic [11:0] io_sys    = 12'h028;
    localparam logic [11:0] io_dswa   = 12'h02C;
    localparam logic [11:0] io_dswb   = 12'h030;
    localparam logic [11:0] io_jmpr   = 12'h034;
    localparam logic [11:0] io_vcount = 12'h03C;

    // gp9001 register offsets, low nibble
    localparam logic [3:0] gcu_ptr    = 4'h0;
    localparam logic [3:0] gcu_ram_h  = 4'h4;
    localparam logic [3:0] gcu_ram_l  = 4'h6;
    localparam logic [3:0] gcu_select = 4'h8;
    localparam logic [3:0] gcu_reg    = 4'hC;

    // one bit per region, at most one set
    typedef struct packed {
        logic rom;
        logic wram;
        logic sram;
        logic io;
        logic gcu;
        logic palram;
        logic txvram;
        logic latch;
    } bus_sel_t;

    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic write_ram;
        logic read_ram_h;
        logic read_ram_l;
        logic set_ram_ptr;
    } gcu_op_t;

endpackage

// File: cpu_bus_if.sv
// 68000 bus bundle with source and sink modports
interface cpu_bus_if;
    import garegga_pkg::*;

    logic [addr_w-1:0] addr;   // word address
    word_t             wdata;
    logic              rw;     // high on read
    logic              uds_n;
    logic              lds_n;
    logic              as_n;

    modport source (
        output addr, wdata, rw, uds_n, lds_n, as_n
    );

    modport sink (
        input addr, wdata, rw, uds_n, lds_n, as_n
    );

endinterface

// File: main_addr_decode.sv
// registered memory-map decoder, region selects and program rom address
module main_addr_decode (
    input  logic                             clk96,
    input  logic                             reset96,
    cpu_bus_if.sink                          bus,
    output garegga_pkg::bus_sel_t            sel,
    output logic                             rom_cs,
    output logic [garegga_pkg::rom_aw-1:0]   rom_addr
);
    import garegga_pkg::*;

    baddr_t   ba;
    bus_sel_t next_sel;

    function automatic logic in_window(input baddr_t a, input baddr_t base, input baddr_t size);
        return (a >= base) && (a < base + size);
    endfunction

    assign ba = {bus.addr, 1'b0};   // byte address, matches the map

    always_comb begin
        next_sel = '0;
        if (!bus.as_n) begin
            next_sel.rom    = ba <= rom_end;
            next_sel.wram   = in_window(ba, wram_base, wram_size);
            next_sel.sram   = in_window(ba, sram_base, sram_size);
            next_sel.io     = in_window(ba, io_page, io_size);
            next_sel.gcu    = in_window(ba, gcu_region, page_1m);
            next_sel.palram = in_window(ba, palram_base, palram_size);
            next_sel.txvram = in_window(ba, txvram_base, txvram_size);
            next_sel.latch  = in_window(ba, latch_region, page_1m);
        end
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96)
            sel <= '0;
        else
            sel <= next_sel;   // drops the cycle after as_n goes high
    end

    // rom word address follows the strobe
    always_ff @(posedge clk96) begin
        if (!bus.as_n)
            rom_addr <= bus.addr[rom_aw-1:0];
    end

    assign rom_cs = sel.rom;

endmodule

// File: dual_port_ram.sv
// dual-port ram, byte-lane writes on port 0, whole-word writes on port 1
module dual_port_ram #(
    parameter int  aw     = 10,
    parameter type data_t = garegga_pkg::word_t
) (
    input  logic                        clk96,
    input  logic [aw-1:0]               addr0,
    input  data_t                       data0,
    input  logic [$bits(data_t)/8-1:0]  we0,     // one per byte lane
    output data_t                       q0,
    input  logic [aw-1:0]               addr1,
    input  data_t                       data1,
    input  logic                        we1,
    output data_t                       q1
);

    data_t mem [2**aw];

    always @(posedge clk96) begin
        for (int i = 0; i < $bits(data_t) / 8; i++) begin
            if (we0[i])
                mem[addr0][i*8 +: 8] <= data0[i*8 +: 8];
        end
        q0 <= mem[addr0];   // old data on collision
    end

    always @(posedge clk96) begin
        if (we1)
            mem[addr1] <= data1;
        q1 <= mem[addr1];
    end

endmodule

// File: main_ram_banks.sv
// work, palette, text and shared sound rams with cpu lane enables
module main_ram_banks (
    input  logic                                 clk96,
    cpu_bus_if.sink                              bus,
    input  garegga_pkg::bus_sel_t                sel,
    output garegga_pkg::word_t                   wram_q,
    output garegga_pkg::word_t                   palram_q,
    output garegga_pkg::word_t                   txvram_q,
    output garegga_pkg::byte_t                   sram_q,
    input  logic [garegga_pkg::palram_aw-1:0]    palram_addr,
    output garegga_pkg::word_t                   palram_data,
    input  logic [garegga_pkg::txvram_aw-1:0]    txvram_addr,
    output garegga_pkg::word_t                   txvram_data,
    input  logic [garegga_pkg::sram_aw-1:0]      sram_addr,
    input  garegga_pkg::byte_t                   sram_din,
    input  logic                                 sram_we,
    output garegga_pkg::byte_t                   sram_data
);
    import garegga_pkg::*;

    logic [1:0] wr_lanes;   // {upper, lower}

    assign wr_lanes = {2{!bus.rw}} & ~{bus.uds_n, bus.lds_n};

    // work ram, cpu only
    dual_port_ram #(.aw(wram_aw), .data_t(word_t)) u_wram (
        .clk96,
        .addr0 (bus.addr[wram_aw-1:0]),
        .data0 (bus.wdata),
        .we0   (wr_lanes & {2{sel.wram}}),
        .q0    (wram_q),
        .addr1 ('0),
        .data1 ('0),
        .we1   (1'b0),
        .q1    ()
    );

    dual_port_ram #(.aw(palram_aw), .data_t(word_t)) u_palram (
        .clk96,
        .addr0 (bus.addr[palram_aw-1:0]),
        .data0 (bus.wdata),
        .we0   (wr_lanes & {2{sel.palram}}),
        .q0    (palram_q),
        .addr1 (palram_addr),   // video side
        .data1 ('0),
        .we1   (1'b0),
        .q1    (palram_data)
    );

    dual_port_ram #(.aw(txvram_aw), .data_t(word_t)) u_txvram (
        .clk96,
        .addr0 (bus.addr[txvram_aw-1:0]),
        .data0 (bus.wdata),
        .we0   (wr_lanes & {2{sel.txvram}}),
        .q0    (txvram_q),
        .addr1 (txvram_addr),
        .data1 ('0),
        .we1   (1'b0),
        .q1    (txvram_data)
    );

    // shared with the sound cpu, low lane only
    dual_port_ram #(.aw(sram_aw), .data_t(byte_t)) u_sram (
        .clk96,
        .addr0 (bus.addr[sram_aw-1:0]),
        .data0 (bus.wdata[7:0]),
        .we0   (wr_lanes[0] & sel.sram),
        .q0    (sram_q),
        .addr1 (sram_addr),
        .data1 (sram_din),
        .we1   (sram_we),
        .q1    (sram_data)
    );

endmodule

// File: cabinet_io.sv
// player inputs, dip switches and video status word by i/o offset
module cabinet_io (
    input  logic                    clk96,
    input  logic                    reset96,
    cpu_bus_if.sink                 bus,
    input  garegga_pkg::bus_sel_t   sel,
    input  logic [9:0]              joystick1,
    input  logic [9:0]              joystick2,
    input  logic [3:0]              start_button,
    input  logic [3:0]              coin_input,
    input  logic                    service,
    input  logic                    dip_test,
    input  garegga_pkg::byte_t      dipsw_a,
    input  garegga_pkg::byte_t      dipsw_b,
    input  garegga_pkg::byte_t      dipsw_c,
    input  logic                    hsync,
    input  logic                    vsync,
    input  logic                    fblank,
    input  logic [8:0]              v,
    output garegga_pkg::word_t      io_q
);
    import garegga_pkg::*;

    logic [11:0] offset;
    byte_t       p1;
    byte_t       p2;
    byte_t       sys_lo;
    byte_t       vline;
    word_t       port_word;

    // inputs are active high, the board reads them inverted
    function automatic byte_t player_byte(input logic [9:0] joy);
        return {1'b0, ~joy[6:4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
    endfunction

    assign offset = {bus.addr[10:0], 1'b0};
    assign p1     = player_byte(joystick1);
    assign p2     = player_byte(joystick2);
    assign sys_lo = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                     ~coin_input[0], ~dip_test, 1'b0, ~service};
    assign vline  = v[8] ? 8'hFF : v[7:0];   // saturates past line 255

    always_comb begin
        case (offset)
            io_in1:    port_word = {p1, p1};
            io_in2:    port_word = {p2, p2};
            io_sys:    port_word = {dipsw_c, sys_lo};
            io_dswa:   port_word = {dipsw_a, dipsw_a};
            io_dswb:   port_word = {dipsw_b, dipsw_b};
            io_jmpr:   port_word = {dipsw_c, dipsw_c};
            io_vcount: port_word = {hsync, vsync, 5'b11111, fblank, vline};
            default:   port_word = '0;
        endcase
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96)
            io_q <= '0;
        else if (sel.io && bus.rw)
            io_q <= port_word;
        else
            io_q <= '0;
    end

endmodule

// File: gcu_sound_ctrl.sv
// gp9001 operation strobes held until ack, sound latch and sound irq
module gcu_sound_ctrl (
    input  logic                    clk96,
    input  logic                    reset96,
    cpu_bus_if.sink                 bus,
    input  garegga_pkg::bus_sel_t   sel,
    input  logic                    gcu_ack,
    output garegga_pkg::gcu_op_t    gcu_op,
    output garegga_pkg::byte_t      sound_latch,
    output logic                    z80_int
);
    import garegga_pkg::*;

    logic [3:0] offset;

    assign offset = {bus.addr[2:0], 1'b0};   // byte offset in the gp9001 window

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            gcu_op      <= '0;
            sound_latch <= '0;
            z80_int     <= 1'b0;
        end else if (sel.latch) begin
            if (!bus.rw) begin
                sound_latch <= bus.wdata[7:0];
                z80_int     <= 1'b1;   // held for the whole access
            end
        end else if (sel.gcu) begin
            if (bus.rw) begin
                case (offset)
                    gcu_ram_h: gcu_op.read_ram_h <= 1'b1;
                    gcu_ram_l: gcu_op.read_ram_l <= 1'b1;
                    default:   ;
                endcase
            end else begin
                case (offset)
                    gcu_reg:              gcu_op.write_reg   <= 1'b1;
                    gcu_select:           gcu_op.select_reg  <= 1'b1;
                    gcu_ram_h, gcu_ram_l: gcu_op.write_ram   <= 1'b1;
                    gcu_ptr:              gcu_op.set_ram_ptr <= 1'b1;
                    default:              ;
                endcase
            end
        end else begin
            z80_int <= 1'b0;
            // strobes only drop together once the video side has taken them
            if (gcu_ack)
                gcu_op <= '0;
        end
    end

endmodule

// File: bus_read_mux.sv
// registered cpu read data selection and busy level for dtack
module bus_read_mux (
    input  logic                    clk96,
    input  logic                    reset96,
    cpu_bus_if.sink                 bus,
    input  garegga_pkg::bus_sel_t   sel,
    input  garegga_pkg::word_t      rom_data,
    input  logic                    rom_ok,
    input  garegga_pkg::word_t      gcu_dout,
    input  logic                    gcu_ack,
    input  garegga_pkg::word_t      wram_q,
    input  garegga_pkg::word_t      palram_q,
    input  garegga_pkg::word_t      txvram_q,
    input  garegga_pkg::word_t      io_q,
    input  garegga_pkg::byte_t      sram_q,
    output garegga_pkg::word_t      cpu_din,
    output logic                    bus_busy
);

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96)
            cpu_din <= '0;
        else if (sel.gcu && bus.rw)
            cpu_din <= gcu_dout;
        else if (sel.rom)
            cpu_din <= rom_data;
        else if (sel.wram && bus.rw)
            cpu_din <= wram_q;
        else if (sel.sram && bus.rw)
            cpu_din <= {8'h00, sram_q};   // byte wide, upper lane reads zero
        else if (sel.palram && bus.rw)
            cpu_din <= palram_q;
        else if (sel.txvram && bus.rw)
            cpu_din <= txvram_q;
        else if (sel.io && bus.rw)
            cpu_din <= io_q;
        else
            cpu_din <= '0;
    end

    // slow sources, the dtack generator waits on this
    assign bus_busy = (sel.rom && !rom_ok) || (sel.gcu && !gcu_ack);

endmodule

// File: garegga_main_bus.sv
// top level of the main-cpu bus glue, plain ports into the decoder, rams, i/o and sound
module garegga_main_bus (
    input  logic                                clk96,
    input  logic                                reset96,
    // 68000 bus
    input  logic [garegga_pkg::addr_w-1:0]      addr,
    input  garegga_pkg::word_t                  cpu_dout,
    input  logic                                rw,
    input  logic                                uds_n,
    input  logic                                lds_n,
    input  logic                                as_n,
    output garegga_pkg::word_t                  cpu_din,
    output logic                                bus_busy,
    // program rom
    output logic                                rom_cs,
    output logic [garegga_pkg::rom_aw-1:0]      rom_addr,
    input  garegga_pkg::word_t                  rom_data,
    input  logic                                rom_ok,
    // gp9001
    output logic                                gcu_select_reg,
    output logic                                gcu_write_reg,
    output logic                                gcu_write_ram,
    output logic                                gcu_read_ram_h,
    output logic                                gcu_read_ram_l,
    output logic                                gcu_set_ram_ptr,
    input  garegga_pkg::word_t                  gcu_dout,
    input  logic                                gcu_ack,
    // cabinet and video status
    input  logic [9:0]                          joystick1,
    input  logic [9:0]                          joystick2,
    input  logic [3:0]                          start_button,
    input  logic [3:0]                          coin_input,
    input  logic                                service,
    input  logic                                dip_test,
    input  garegga_pkg::byte_t                  dipsw_a,
    input  garegga_pkg::byte_t                  dipsw_b,
    input  garegga_pkg::byte_t                  dipsw_c,
    input  logic                                hsync,
    input  logic                                vsync,
    input  logic                                fblank,
    input  logic [8:0]                          v,
    // video side ram ports
    input  logic [garegga_pkg::palram_aw-1:0]   palram_addr,
    output garegga_pkg::word_t                  palram_data,
    input  logic [garegga_pkg::txvram_aw-1:0]   txvram_addr,
    output garegga_pkg::word_t                  txvram_data,
    // sound side
    input  logic [garegga_pkg::sram_aw-1:0]     sram_addr,
    input  garegga_pkg::byte_t                  sram_din,
    input  logic                                sram_we,
    output garegga_pkg::byte_t                  sram_data,
    output garegga_pkg::byte_t                  sound_latch,
    output logic                                z80_int
);
    import garegga_pkg::*;

    bus_sel_t sel;
    gcu_op_t  gcu_op;
    word_t    wram_q;
    word_t    palram_q;
    word_t    txvram_q;
    word_t    io_q;
    byte_t    sram_q;

    cpu_bus_if bus ();

    assign bus.addr  = addr;
    assign bus.wdata = cpu_dout;
    assign bus.rw    = rw;
    assign bus.uds_n = uds_n;
    assign bus.lds_n = lds_n;
    assign bus.as_n  = as_n;

    assign {gcu_select_reg, gcu_write_reg, gcu_write_ram,
            gcu_read_ram_h, gcu_read_ram_l, gcu_set_ram_ptr} = gcu_op;

    main_addr_decode u_decode (.clk96, .reset96, .bus, .sel, .rom_cs, .rom_addr);

    main_ram_banks u_rams (
        .clk96, .bus, .sel,
        .wram_q, .palram_q, .txvram_q, .sram_q,
        .palram_addr, .palram_data, .txvram_addr, .txvram_data,
        .sram_addr, .sram_din, .sram_we, .sram_data
    );

    cabinet_io u_io (
        .clk96, .reset96, .bus, .sel,
        .joystick1, .joystick2, .start_button, .coin_input, .service, .dip_test,
        .dipsw_a, .dipsw_b, .dipsw_c, .hsync, .vsync, .fblank, .v, .io_q
    );

    gcu_sound_ctrl u_gcu_snd (
        .clk96, .reset96, .bus, .sel, .gcu_ack, .gcu_op, .sound_latch, .z80_int
    );

    bus_read_mux u_rdmux (
        .clk96, .reset96, .bus, .sel,
        .rom_data, .rom_ok, .gcu_dout, .gcu_ack,
        .wram_q, .palram_q, .txvram_q, .io_q, .sram_q,
        .cpu_din, .bus_busy
    );

endmodule

// File: tb_bus_tasks.svh
// 68000 bus-cycle tasks and expected i/o port words for the testbench
`ifndef tb_bus_tasks_svh
`define tb_bus_tasks_svh

// one access, as_n low for four cycles then high for one
task automatic bus_cycle(input baddr_t ba, input logic rd, input word_t wd,
                         input logic [1:0] lanes_n, output word_t rdata);
    @(posedge clk96);
    addr           <= ba[23:1];
    rw             <= rd;
    cpu_dout       <= wd;
    {uds_n, lds_n} <= lanes_n;
    as_n           <= 1'b0;
    repeat (3) @(posedge clk96);
    @(negedge clk96);   // fourth cycle, E0 + 2 has passed
    rdata     = cpu_din;
    busy_seen = bus_busy;
    op_seen   = strobes;
    cs_seen   = rom_cs;
    addr_seen = rom_addr;
    @(posedge clk96);
    as_n <= 1'b1;
endtask

task automatic bus_write(input baddr_t ba, input word_t wd, input logic [1:0] lanes_n);
    word_t ignored;
    bus_cycle(ba, 1'b0, wd, lanes_n, ignored);
endtask

task automatic bus_read(input baddr_t ba, output word_t rdata);
    bus_cycle(ba, 1'b1, 16'h0000, 2'b00, rdata);
endtask

// player byte, bit 7 clear, active-low inputs, low nibble reversed
function automatic byte_t player_expected(input logic [9:0] joy);
    byte_t b;
    b = 8'h00;
    for (int i = 4; i < 7; i++)
        b[i] = !joy[i];
    for (int i = 0; i < 4; i++)
        b[3 - i] = !joy[i];
    return b;
endfunction

function automatic word_t io_expected(input logic [11:0] off);
    byte_t lo;
    byte_t hi;
    lo = 8'h00;
    hi = 8'hFF;
    if (off == io_sys) begin
        lo[6] = !start_button[1];
        lo[5] = !start_button[0];
        lo[4] = !coin_input[1];
        lo[3] = !coin_input[0];
        lo[2] = !dip_test;
        lo[0] = !service;
        return {dipsw_c, lo};
    end
    if (off == io_vcount) begin
        if (!hsync)
            hi[7] = 1'b0;
        if (!vsync)
            hi[6] = 1'b0;
        if (!fblank)
            hi[0] = 1'b0;
        lo = (v < 9'd256) ? v[7:0] : 8'hFF;
        return {hi, lo};
    end
    case (off)
        io_in1:  return {2{player_expected(joystick1)}};
        io_in2:  return {2{player_expected(joystick2)}};
        io_dswa: return {2{dipsw_a}};
        io_dswb: return {2{dipsw_b}};
        io_jmpr: return {2{dipsw_c}};
        default: return 16'h0000;
    endcase
endfunction

`endif

// File: tb_garegga_main_bus.sv
// testbench for the main-cpu bus glue with clock, reset, stimulus, assertions and watchdog
module tb_garegga_main_bus;
    import garegga_pkg::*;

    localparam int n_ram    = 6;   // entries per ram
    localparam int n_sram   = 4;
    localparam int n_access = 3 * n_ram * 3 + 2 * n_sram + 2 * 8 + 7 + 3;
    localparam int watchdog_time = n_access * 5 * 10 + 3000;

    logic                 clk96;
    logic                 reset96;
    logic [addr_w-1:0]    addr;
    word_t                cpu_dout;
    logic                 rw;
    logic                 uds_n;
    logic                 lds_n;
    logic                 as_n;
    word_t                cpu_din;
    logic                 bus_busy;
    logic                 rom_cs;
    logic [rom_aw-1:0]    rom_addr;
    word_t                rom_data;
    logic                 rom_ok;
    logic                 gcu_select_reg;
    logic                 gcu_write_reg;
    logic                 gcu_write_ram;
    logic                 gcu_read_ram_h;
    logic                 gcu_read_ram_l;
    logic                 gcu_set_ram_ptr;
    word_t                gcu_dout;
    logic                 gcu_ack;
    logic [9:0]           joystick1;
    logic [9:0]           joystick2;
    logic [3:0]           start_button;
    logic [3:0]           coin_input;
    logic                 service;
    logic                 dip_test;
    byte_t                dipsw_a;
    byte_t                dipsw_b;
    byte_t                dipsw_c;
    logic                 hsync;
    logic                 vsync;
    logic                 fblank;
    logic [8:0]           v;
    logic [palram_aw-1:0] palram_addr;
    word_t                palram_data;
    logic [txvram_aw-1:0] txvram_addr;
    word_t                txvram_data;
    logic [sram_aw-1:0]   sram_addr;
    byte_t                sram_din;
    logic                 sram_we;
    byte_t                sram_data;
    byte_t                sound_latch;
    logic                 z80_int;

    logic [5:0]           strobes;
    logic [5:0]           op_seen;    // snapshots taken in the fourth cycle
    logic                 busy_seen;
    logic                 cs_seen;
    logic [rom_aw-1:0]    addr_seen;
    integer               seed;

    assign strobes = {gcu_select_reg, gcu_write_reg, gcu_write_ram,
                      gcu_read_ram_h, gcu_read_ram_l, gcu_set_ram_ptr};

    garegga_main_bus dut0 (.*);

    task automatic end_with_failure();
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("%s (time %0t)", what, $time);
        end_with_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp)
        else begin
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, got);
            end_with_failure();
        end
    endtask

    `include "tb_bus_tasks.svh"

    initial begin
        clk96 = 1'b0;
        forever #5 clk96 = ~clk96;
    end

    assert property (@(posedge clk96) (reset96 && $past(reset96)) |->
                     (strobes == 6'd0 && !z80_int && !rom_cs && !bus_busy &&
                      sound_latch == 8'h00 && cpu_din == 16'h0000))
        else report_problem("outputs were not idle during reset");

    assert property (@(posedge clk96) $onehot0(strobes))
        else report_problem("more than one gp9001 strobe was high");

    // busy follows rom_ok for as long as the rom is selected
    assert property (@(posedge clk96) disable iff (reset96)
                     rom_cs |-> (bus_busy == !rom_ok))
        else report_problem("bus_busy did not follow rom_ok during a rom access");

    initial begin
        #(watchdog_time);
        report_problem("watchdog expired before the tests finished");
    end

    // video port returns the word one cycle after its address
    task automatic video_check(input int port, input int index, input word_t exp);
        @(posedge clk96);
        if (port == 1)
            palram_addr <= index;
        else
            txvram_addr <= index;
        @(posedge clk96);
        @(negedge clk96);
        if (port == 1)
            check_value("palram_data", exp, palram_data);
        else
            check_value("txvram_data", exp, txvram_data);
    endtask

    task automatic ram_test(input baddr_t base, input baddr_t size, input int port);
        baddr_t where [n_ram];
        word_t  shadow [n_ram];
        baddr_t span;
        word_t  wd;
        word_t  got;
        span = size / n_ram;
        for (int i = 0; i < n_ram; i++) begin
            where[i]  = base + i * span + (({$random(seed)} % span) & ~24'd1);
            shadow[i] = $random(seed);
            bus_write(where[i], shadow[i], 2'b00);
        end
        for (int i = 0; i < n_ram; i++) begin
            wd = $random(seed);
            if (i % 2 == 0) begin
                bus_write(where[i], wd, 2'b01);   // upper lane
                shadow[i][15:8] = wd[15:8];
            end else begin
                bus_write(where[i], wd, 2'b10);
                shadow[i][7:0] = wd[7:0];
            end
        end
        for (int i = 0; i < n_ram; i++) begin
            bus_read(where[i], got);
            check_value("cpu_din", shadow[i], got);
            if (port != 0)
                video_check(port, (where[i] - base) >> 1, shadow[i]);
        end
    endtask

    task automatic sram_test();
        baddr_t ba;
        word_t  wd;
        word_t  got;
        byte_t  sb;
        int     index;
        for (int i = 0; i < n_sram; i++) begin
            index = i * 2048 + ({$random(seed)} % 2048);
            ba    = sram_base + 2 * index;
            wd    = $random(seed);
            bus_write(ba, wd, 2'b00);
            @(posedge clk96);
            sram_addr <= index;
            @(posedge clk96);
            @(negedge clk96);
            check_value("sram_data", wd[7:0], sram_data);
            // sound side write read back by the main cpu
            sb = $random(seed);
            @(posedge clk96);
            sram_din <= sb;
            sram_we  <= 1'b1;
            @(posedge clk96);
            sram_we <= 1'b0;
            bus_read(ba, got);
            check_value("cpu_din", {8'h00, sb}, got);
        end
    endtask

    task automatic io_test();
        logic [11:0] offs [8];
        word_t       got;
        offs = '{io_in1, io_in2, io_sys, io_dswa, io_dswb, io_jmpr, io_vcount, 12'h040};
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 8; i++) begin
                @(posedge clk96);
                {joystick1, joystick2} <= $random(seed);
                {start_button, coin_input, service, dip_test, hsync, vsync, fblank} <=
                    $random(seed);
                {dipsw_a, dipsw_b, dipsw_c} <= $random(seed);
                v <= {round == 1, 8'($random(seed))};   // second round past line 255
                bus_read(io_page + offs[i], got);
                check_value("cpu_din", io_expected(offs[i]), got);
            end
        end
    endtask

    task automatic gcu_test();
        logic [3:0] offs [7];
        logic       reads [7];
        logic [5:0] exp_op [7];
        baddr_t     ba;
        word_t      got;
        offs   = '{4'h0, 4'h4, 4'h6, 4'h8, 4'hC, 4'h4, 4'h6};
        reads  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
        exp_op = '{6'b000001, 6'b001000, 6'b001000, 6'b100000, 6'b010000,
                   6'b000100, 6'b000010};
        for (int i = 0; i < 7; i++) begin
            ba = gcu_region + ({$random(seed)} & 24'h0F_FFF0) + offs[i];
            @(posedge clk96);
            gcu_dout <= $random(seed);
            bus_cycle(ba, reads[i], $random(seed), 2'b00, got);
            check_value("gcu strobes", exp_op[i], op_seen);
            check_value("bus_busy", 1'b1, busy_seen);
            if (reads[i])
                check_value("cpu_din", gcu_dout, got);
            repeat (3) @(posedge clk96);   // access over but ack still low
            @(negedge clk96);
            check_value("gcu strobes", exp_op[i], strobes);
            @(posedge clk96);
            gcu_ack <= 1'b1;
            @(posedge clk96);
            @(negedge clk96);
            check_value("gcu strobes", 6'd0, strobes);
            @(posedge clk96);
            gcu_ack <= 1'b0;
        end
    endtask

    task automatic latch_rom_test();
        baddr_t ba;
        word_t  wd;
        word_t  got;
        ba = latch_region + ({$random(seed)} & 24'h0F_FFFE);
        wd = $random(seed);
        bus_write(ba, wd, 2'b00);
        @(negedge clk96);
        check_value("sound_latch", wd[7:0], sound_latch);
        check_value("z80_int", 1'b1, z80_int);
        repeat (2) @(posedge clk96);
        @(negedge clk96);
        check_value("z80_int", 1'b0, z80_int);
        // rom held busy and rom_ok rising inside the next access
        ba = {$random(seed)} & 24'h0F_FFFE;
        @(posedge clk96);
        rom_ok   <= 1'b0;
        rom_data <= $random(seed);
        bus_read(ba, got);
        check_value("rom_cs", 1'b1, cs_seen);
        check_value("rom_addr", ba[19:1], addr_seen);
        check_value("bus_busy", 1'b1, busy_seen);
        check_value("cpu_din", rom_data, got);
        fork
            bus_read(ba, got);
            begin
                repeat (3) @(posedge clk96);
                rom_ok <= 1'b1;
            end
        join
        check_value("bus_busy", 1'b0, busy_seen);
        check_value("cpu_din", rom_data, got);
    endtask

    initial begin
        seed    = 32'hf559_73b6;
        reset96 = 1'b1;
        addr    = '0;
        cpu_dout = 16'h0000;
        rw      = 1'b1;
        uds_n   = 1'b1;
        lds_n   = 1'b1;
        as_n    = 1'b1;
        rom_data = 16'h0000;
        rom_ok  = 1'b0;
        gcu_dout = 16'h0000;
        gcu_ack = 1'b0;
        {joystick1, joystick2, start_button, coin_input} = '0;
        {service, dip_test, hsync, vsync, fblank} = '1;
        {dipsw_a, dipsw_b, dipsw_c} = '0;
        v       = 9'd0;
        palram_addr = '0;
        txvram_addr = '0;
        sram_addr = '0;
        sram_din = 8'h00;
        sram_we = 1'b0;
        repeat (8) @(posedge clk96);
        reset96 <= 1'b0;
        @(posedge clk96);
        @(negedge clk96);
        check_value("gcu strobes", 6'd0, strobes);
        check_value("z80_int", 1'b0, z80_int);
        check_value("rom_cs", 1'b0, rom_cs);
        check_value("bus_busy", 1'b0, bus_busy);
        check_value("sound_latch", 8'h00, sound_latch);
        check_value("cpu_din", 16'h0000, cpu_din);

        ram_test(wram_base, wram_size, 0);
        ram_test(palram_base, palram_size, 1);
        ram_test(txvram_base, txvram_size, 2);
        sram_test();
        io_test();
        gcu_test();
        latch_rom_test();

        $display("Everything OK");
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
garegga_pkg.sv
cpu_bus_if.sv
main_addr_decode.sv
dual_port_ram.sv
main_ram_banks.sv
cabinet_io.sv
gcu_sound_ctrl.sv
bus_read_mux.sv
garegga_main_bus.sv
tb_garegga_main_bus.sv

// File: Bender.yml
package:
  name: garegga_main_bus

sources:
  - files:
      - garegga_pkg.sv
      - cpu_bus_if.sv
      - main_addr_decode.sv
      - dual_port_ram.sv
      - main_ram_banks.sv
      - cabinet_io.sv
      - gcu_sound_ctrl.sv
      - bus_read_mux.sv
      - garegga_main_bus.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_garegga_main_bus.sv
